// ==== verilog/arcade_pkg.sv ====
// arcade wrapper shared definitions
// button, stick, dip and video bundles plus the bridge address map
// and the adapter thresholds used by the input router

package arcade_pkg;

    // handheld and adapter button map, up in bit 0
    typedef struct packed {
        logic start;
        logic select;
        logic r3;
        logic l3;
        logic r2;
        logic l2;
        logic r1;
        logic l1;
        logic y;
        logic x;
        logic b;
        logic a;
        logic right;
        logic left;
        logic down;
        logic up;
    } key_t;

    // unsigned stick bytes, lstick_x in the low byte
    typedef struct packed {
        logic [7:0] rstick_y;
        logic [7:0] rstick_x;
        logic [7:0] lstick_y;
        logic [7:0] lstick_x;
    } joy_t;

    // dip word as the game samples it, bonus at the bottom
    typedef struct packed {
        logic       demo_sounds;
        logic       spare1;
        logic [1:0] lives;
        logic [5:0] spare6;
        logic [2:0] difficulty;
        logic [2:0] bonus;
    } dip_t;

    // adapter config, enable in the top bit
    typedef struct packed {
        logic       enable;
        logic [4:0] cont_type;
        logic [1:0] assignment;
        logic       blank_screen;
    } adapter_cfg_t;

    // game control word, coin in bit 0
    typedef struct packed {
        logic up;
        logic down;
        logic left;
        logic right;
        logic fire;
        logic start;
        logic coin;
    } game_ctrl_t;

    typedef struct packed {
        logic [11:0] rgb12;
        logic        hblank;
        logic        vblank;
        logic        hsync;
        logic        vsync;
    } video_in_t;

    typedef struct packed {
        logic [23:0] rgb;
        logic        de;
        logic        hs;
        logic        vs;
    } video_out_t;

    ////////////////////////////////////////////////////////////////////////////
    // bridge address map, one word each
    ////////////////////////////////////////////////////////////////////////////
    localparam logic [31:0] ADDR_LIVES       = 32'h2000_0000;
    localparam logic [31:0] ADDR_DIFFICULTY  = 32'h3000_0000;
    localparam logic [31:0] ADDR_BONUS       = 32'h4000_0000;
    localparam logic [31:0] ADDR_DEMO        = 32'h5000_0000;
    localparam logic [31:0] ADDR_RESET       = 32'h8000_0000;
    localparam logic [31:0] ADDR_ADAPTER_EN  = 32'hF200_0000;
    localparam logic [31:0] ADDR_ADAPTER_CFG = 32'hF700_0000;

    // stick d-pad thresholds, idle sits near 0x80
    localparam logic [7:0] STICK_LOW  = 8'h40;
    localparam logic [7:0] STICK_HIGH = 8'hC0;

    // controller types that report analog sticks
    localparam logic [4:0] CONT_ANALOG_A = 5'h12;
    localparam logic [4:0] CONT_ANALOG_B = 5'h13;

endpackage

// ==== verilog/sync_stage.sv ====
// three-flop synchronizer
// brings an asynchronous payload of any packed type into clk_74a

`timescale 1ns/10ps

module sync_stage #(
    parameter type payload_t = logic
) (
    input  logic     clk_74a,
    input  logic     arst_n,
    input  payload_t d,
    output payload_t q
);

    // first two stages absorb metastability
    payload_t meta_q;
    payload_t mid_q;

    always_ff @(posedge clk_74a or negedge arst_n) begin
        if (!arst_n) begin
            meta_q <= '0;
            mid_q  <= '0;
            q      <= '0;
        end else begin
            meta_q <= d;
            mid_q  <= meta_q;
            q      <= mid_q;
        end
    end

endmodule

// ==== verilog/bridge_regs.sv ====
// bridge register file
// decodes bridge writes into dip fields, adapter enable and config,
// flips the manual reset toggle and muxes read-back data

`timescale 1ns/10ps

module bridge_regs
    import arcade_pkg::*;
(
    input  logic         clk_74a,
    input  logic         arst_n,
    input  logic         bridge_wr,
    input  logic [31:0]  bridge_addr,
    input  logic [31:0]  bridge_wr_data,
    output logic [31:0]  bridge_rd_data,
    output dip_t         dips,
    output adapter_cfg_t cfg,
    output logic         reset_toggle
);

    // game dip fields
    logic [1:0] lives_q;
    logic [2:0] difficulty_q;
    logic [2:0] bonus_q;
    logic       demo_q;

    ////////////////////////////////////////////////////////////////////////////
    // write decode
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_74a or negedge arst_n) begin
        if (!arst_n) begin
            lives_q      <= '0;
            difficulty_q <= '0;
            bonus_q      <= '0;
            demo_q       <= 1'b0;
            cfg          <= '0;
            reset_toggle <= 1'b0;
        end else if (bridge_wr) begin
            case (bridge_addr)
                ADDR_LIVES:       lives_q      <= bridge_wr_data[1:0];
                ADDR_DIFFICULTY:  difficulty_q <= bridge_wr_data[2:0];
                ADDR_BONUS:       bonus_q      <= bridge_wr_data[2:0];
                ADDR_DEMO:        demo_q       <= bridge_wr_data[0];
                // enable alone, rest of the config kept
                ADDR_ADAPTER_EN:  cfg.enable   <= bridge_wr_data[0];
                // whole config word, enable included
                ADDR_ADAPTER_CFG: cfg          <= adapter_cfg_t'(bridge_wr_data[8:0]);
                // data ignored, any write requests a reset
                ADDR_RESET:       reset_toggle <= ~reset_toggle;
                default: begin
                end
            endcase
        end
    end

    // spare dip bits read as zero by the game
    assign dips = '{
        demo_sounds: demo_q,
        spare1:      1'b0,
        lives:       lives_q,
        spare6:      6'd0,
        difficulty:  difficulty_q,
        bonus:       bonus_q
    };

    ////////////////////////////////////////////////////////////////////////////
    // read mux, follows bridge_addr directly
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        bridge_rd_data = '0;
        case (bridge_addr)
            ADDR_ADAPTER_EN:  bridge_rd_data = {31'd0, cfg.enable};
            ADDR_ADAPTER_CFG: bridge_rd_data = {23'd0, cfg};
            default: begin
            end
        endcase
    end

endmodule

// ==== verilog/reset_stretch.sv ====
// manual reset stretcher
// a change of the bridge toggle while idle holds core_reset
// high for RESET_CYCLES cycles

`timescale 1ns/10ps

module reset_stretch #(
    parameter int unsigned RESET_CYCLES = 2 ** 21
) (
    input  logic clk_74a,
    input  logic arst_n,
    input  logic reset_toggle,
    output logic core_reset
);

    // counter only has to reach RESET_CYCLES - 1
    localparam int CNT_W = (RESET_CYCLES > 1) ? $clog2(RESET_CYCLES) : 1;

    logic             toggle_q;
    logic [CNT_W-1:0] count_q;

    always_ff @(posedge clk_74a or negedge arst_n) begin
        if (!arst_n) begin
            toggle_q   <= 1'b0;
            count_q    <= '0;
            core_reset <= 1'b0;
        end else begin
            // tracked every cycle so a toggle inside the window is absorbed
            toggle_q <= reset_toggle;
            if (!core_reset) begin
                if (reset_toggle != toggle_q) begin
                    core_reset <= 1'b1;
                    count_q    <= CNT_W'(RESET_CYCLES - 1);
                end
            end else if (count_q == '0) begin
                core_reset <= 1'b0;
            end else begin
                count_q <= count_q - 1'b1;
            end
        end
    end

endmodule

// ==== verilog/input_router.sv ====
// player input router
// picks handheld keys or adapter players for game p1/p2,
// converts the adapter left stick to d-pad bits on analog pads

`timescale 1ns/10ps

module input_router
    import arcade_pkg::*;
(
    input  logic         clk_74a,
    input  logic         arst_n,
    input  adapter_cfg_t cfg,
    input  key_t         cont1_key,
    input  key_t         cont2_key,
    input  key_t         snac_p1_btn,
    input  key_t         snac_p2_btn,
    input  joy_t         snac_p1_joy,
    input  joy_t         snac_p2_joy,
    output key_t         p1_ctrl,
    output key_t         p2_ctrl
);

    logic snac_is_analog;
    logic snac_off;
    key_t snac_p1_pad;
    key_t snac_p2_pad;

    // adapter buttons with the d-pad taken from the stick on analog pads
    function automatic key_t adapter_pad(input key_t btn, input joy_t joy,
                                         input logic analog);
        key_t pad;
        pad = btn;
        if (analog) begin
            // y grows downward, x grows to the right
            pad.up    = joy.lstick_y < STICK_LOW;
            pad.down  = joy.lstick_y > STICK_HIGH;
            pad.left  = joy.lstick_x < STICK_LOW;
            pad.right = joy.lstick_x > STICK_HIGH;
        end
        return pad;
    endfunction

    assign snac_is_analog = (cfg.cont_type == CONT_ANALOG_A) ||
                            (cfg.cont_type == CONT_ANALOG_B);

    // no controller type selected counts as adapter off
    assign snac_off = !cfg.enable || (cfg.cont_type == 5'd0);

    assign snac_p1_pad = adapter_pad(snac_p1_btn, snac_p1_joy, snac_is_analog);
    assign snac_p2_pad = adapter_pad(snac_p2_btn, snac_p2_joy, snac_is_analog);

    ////////////////////////////////////////////////////////////////////////////
    // player assignment, one register stage
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_74a or negedge arst_n) begin
        if (!arst_n) begin
            p1_ctrl <= '0;
            p2_ctrl <= '0;
        end else if (snac_off) begin
            p1_ctrl <= cont1_key;
            p2_ctrl <= cont2_key;
        end else begin
            case (cfg.assignment)
                // adapter p1 plays, handheld moves to p2
                2'd0: begin
                    p1_ctrl <= snac_p1_pad;
                    p2_ctrl <= cont1_key;
                end
                // handheld plays, raw adapter buttons on p2
                2'd1: begin
                    p1_ctrl <= cont1_key;
                    p2_ctrl <= snac_p1_btn;
                end
                // both adapter players straight through
                2'd2: begin
                    p1_ctrl <= snac_p1_pad;
                    p2_ctrl <= snac_p2_pad;
                end
                // adapter players crossed over
                default: begin
                    p1_ctrl <= snac_p2_pad;
                    p2_ctrl <= snac_p1_pad;
                end
            endcase
        end
    end

endmodule

// ==== verilog/game_control_stage.sv ====
// game control stage
// stretches the release of p1 select into a coin pulse and
// registers the control word the game core samples

`timescale 1ns/10ps

module game_control_stage
    import arcade_pkg::*;
#(
    parameter int unsigned COIN_CYCLES = 2 ** 20 - 1
) (
    input  logic       clk_74a,
    input  logic       arst_n,
    input  key_t       p1_ctrl,
    output game_ctrl_t game_ctrl
);

    // counter only has to reach COIN_CYCLES - 1
    localparam int CNT_W = (COIN_CYCLES > 1) ? $clog2(COIN_CYCLES) : 1;

    logic             select_q;
    logic             coin_active;
    logic [CNT_W-1:0] coin_cnt;

    ////////////////////////////////////////////////////////////////////////////
    // coin pulse
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_74a or negedge arst_n) begin
        if (!arst_n) begin
            select_q    <= 1'b0;
            coin_active <= 1'b0;
            coin_cnt    <= '0;
        end else begin
            select_q <= p1_ctrl.select;
            if (!coin_active) begin
                // release of select, edges during a pulse fall through
                if (select_q && !p1_ctrl.select) begin
                    coin_active <= 1'b1;
                    coin_cnt    <= CNT_W'(COIN_CYCLES - 1);
                end
            end else if (coin_cnt == '0) begin
                coin_active <= 1'b0;
            end else begin
                coin_cnt <= coin_cnt - 1'b1;
            end
        end
    end

    // control word, face button a is fire
    always_ff @(posedge clk_74a or negedge arst_n) begin
        if (!arst_n) begin
            game_ctrl <= '0;
        end else begin
            game_ctrl.up    <= p1_ctrl.up;
            game_ctrl.down  <= p1_ctrl.down;
            game_ctrl.left  <= p1_ctrl.left;
            game_ctrl.right <= p1_ctrl.right;
            game_ctrl.fire  <= p1_ctrl.a;
            game_ctrl.start <= p1_ctrl.start;
            game_ctrl.coin  <= coin_active;
        end
    end

endmodule

// ==== verilog/video_formatter.sv ====
// video output stage
// 12-bit to 24-bit colour, data enable from the blanks,
// optional handheld screen blank and one-cycle sync pulses

`timescale 1ns/10ps

module video_formatter
    import arcade_pkg::*;
(
    input  logic         clk_74a,
    input  logic         arst_n,
    input  adapter_cfg_t cfg,
    input  video_in_t    vin,
    output video_out_t   vout
);

    logic        de;
    logic        screen_off;
    logic        hsync_q;
    logic        vsync_q;
    logic [23:0] rgb24;

    assign de = !(vin.hblank || vin.vblank);

    // screen blank only applies with the adapter on
    assign screen_off = cfg.blank_screen && cfg.enable;

    // duplicate each nibble, r in the top byte
    assign rgb24 = {{2{vin.rgb12[11:8]}}, {2{vin.rgb12[7:4]}}, {2{vin.rgb12[3:0]}}};

    ////////////////////////////////////////////////////////////////////////////
    // timing outputs and pixel data
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_74a or negedge arst_n) begin
        if (!arst_n) begin
            hsync_q <= 1'b0;
            vsync_q <= 1'b0;
            vout    <= '0;
        end else begin
            hsync_q <= vin.hsync;
            vsync_q <= vin.vsync;
            vout.de <= de;
            // rising edge only
            vout.hs <= vin.hsync && !hsync_q;
            vout.vs <= vin.vsync && !vsync_q;
            // pixel data
            if (!de || screen_off) begin
                vout.rgb <= '0;
            end else begin
                vout.rgb <= rgb24;
            end
        end
    end

endmodule

// ==== verilog/arcade_top.sv ====
// arcade wrapper top level
// bridge registers, manual reset, adapter synchronizers,
// input routing, game control word and video output

`timescale 1ns/10ps

module arcade_top
    import arcade_pkg::*;
#(
    parameter int unsigned RESET_CYCLES = 2 ** 21,
    parameter int unsigned COIN_CYCLES  = 2 ** 20 - 1
) (
    input  logic        clk_74a,
    input  logic        arst_n,
    input  logic        bridge_wr,
    input  logic [31:0] bridge_addr,
    input  logic [31:0] bridge_wr_data,
    output logic [31:0] bridge_rd_data,
    input  key_t        cont1_key,
    input  key_t        cont2_key,
    input  key_t        snac_p1_btn,
    input  key_t        snac_p2_btn,
    input  joy_t        snac_p1_joy,
    input  joy_t        snac_p2_joy,
    input  video_in_t   vin,
    output video_out_t  vout,
    output game_ctrl_t  game_ctrl,
    output dip_t        dips,
    output logic        core_reset
);

    adapter_cfg_t cfg;
    logic         reset_toggle;
    key_t         p1_btn_s;
    key_t         p2_btn_s;
    joy_t         p1_joy_s;
    joy_t         p2_joy_s;
    key_t         p1_ctrl;

    ////////////////////////////////////////////////////////////////////////////
    // bridge and manual reset
    ////////////////////////////////////////////////////////////////////////////
    bridge_regs u_bridge_regs (
        .clk_74a        (clk_74a),
        .arst_n         (arst_n),
        .bridge_wr      (bridge_wr),
        .bridge_addr    (bridge_addr),
        .bridge_wr_data (bridge_wr_data),
        .bridge_rd_data (bridge_rd_data),
        .dips           (dips),
        .cfg            (cfg),
        .reset_toggle   (reset_toggle)
    );

    reset_stretch #(.RESET_CYCLES(RESET_CYCLES)) u_reset_stretch (
        .clk_74a      (clk_74a),
        .arst_n       (arst_n),
        .reset_toggle (reset_toggle),
        .core_reset   (core_reset)
    );

    ////////////////////////////////////////////////////////////////////////////
    // adapter inputs arrive asynchronously
    ////////////////////////////////////////////////////////////////////////////
    sync_stage #(.payload_t(key_t)) u_sync_p1_btn (
        .clk_74a (clk_74a), .arst_n (arst_n), .d (snac_p1_btn), .q (p1_btn_s)
    );

    sync_stage #(.payload_t(key_t)) u_sync_p2_btn (
        .clk_74a (clk_74a), .arst_n (arst_n), .d (snac_p2_btn), .q (p2_btn_s)
    );

    sync_stage #(.payload_t(joy_t)) u_sync_p1_joy (
        .clk_74a (clk_74a), .arst_n (arst_n), .d (snac_p1_joy), .q (p1_joy_s)
    );

    sync_stage #(.payload_t(joy_t)) u_sync_p2_joy (
        .clk_74a (clk_74a), .arst_n (arst_n), .d (snac_p2_joy), .q (p2_joy_s)
    );

    // routing then control word, two cycles from a key change
    // game p2 has no consumer, this game is single player on the wire
    input_router u_input_router (
        .clk_74a     (clk_74a),
        .arst_n      (arst_n),
        .cfg         (cfg),
        .cont1_key   (cont1_key),
        .cont2_key   (cont2_key),
        .snac_p1_btn (p1_btn_s),
        .snac_p2_btn (p2_btn_s),
        .snac_p1_joy (p1_joy_s),
        .snac_p2_joy (p2_joy_s),
        .p1_ctrl     (p1_ctrl),
        .p2_ctrl     ()
    );

    game_control_stage #(.COIN_CYCLES(COIN_CYCLES)) u_game_control_stage (
        .clk_74a   (clk_74a),
        .arst_n    (arst_n),
        .p1_ctrl   (p1_ctrl),
        .game_ctrl (game_ctrl)
    );

    video_formatter u_video_formatter (
        .clk_74a (clk_74a),
        .arst_n  (arst_n),
        .cfg     (cfg),
        .vin     (vin),
        .vout    (vout)
    );

endmodule

// ==== tests/arcade_props.sv ====
// timing rules of the arcade wrapper
// reset window, coin pulse, control word latency and sync pulses

`timescale 1ns/10ps

module arcade_props
    import arcade_pkg::*;
(
    input logic         clk_74a,
    input logic         arst_n,
    input logic         bridge_wr,
    input logic [31:0]  bridge_addr,
    input logic         core_reset,
    input adapter_cfg_t cfg,
    input key_t         cont1_key,
    input key_t         p1_ctrl,
    input logic         coin_active,
    input game_ctrl_t   game_ctrl,
    input video_in_t    vin,
    input video_out_t   vout
);

    // reset request while idle, core reset two cycles on
    a_reset_start: assert property (@(posedge clk_74a) disable iff (!arst_n)
        bridge_wr && bridge_addr == ADDR_RESET && !core_reset |-> ##2 $rose(core_reset))
        else $error("core_reset did not rise two cycles after the reset write");

    // window of exactly sixteen cycles
    a_reset_len: assert property (@(posedge clk_74a) disable iff (!arst_n)
        $fell(core_reset) |-> $past(core_reset, 16) && !$past(core_reset, 17))
        else $error("core_reset window length wrong");

    a_coin_start: assert property (@(posedge clk_74a) disable iff (!arst_n)
        $fell(p1_ctrl.select) && !coin_active |-> ##2 game_ctrl.coin)
        else $error("coin pulse did not start two cycles after release");

    // eight cycles, edges inside the pulse ignored
    a_coin_len: assert property (@(posedge clk_74a) disable iff (!arst_n)
        $fell(game_ctrl.coin) |-> $past(game_ctrl.coin, 8) && !$past(game_ctrl.coin, 9))
        else $error("coin pulse length wrong");

    a_key_follow: assert property (@(posedge clk_74a) disable iff (!arst_n)
        !cfg.enable |-> ##2
        {game_ctrl.up, game_ctrl.down, game_ctrl.left, game_ctrl.right,
         game_ctrl.fire, game_ctrl.start} ==
        $past({cont1_key.up, cont1_key.down, cont1_key.left, cont1_key.right,
               cont1_key.a, cont1_key.start}, 2))
        else $error("game_ctrl did not follow cont1_key");

    a_de: assert property (@(posedge clk_74a) disable iff (!arst_n)
        1 |=> vout.de == $past(!(vin.hblank || vin.vblank)))
        else $error("data enable latency wrong");

    a_hs_rise: assert property (@(posedge clk_74a) disable iff (!arst_n)
        $rose(vin.hsync) |=> vout.hs)
        else $error("hs pulse missing");

    a_hs_only: assert property (@(posedge clk_74a) disable iff (!arst_n)
        !$rose(vin.hsync) |=> !vout.hs)
        else $error("hs pulse without rising edge");

    a_vs_rise: assert property (@(posedge clk_74a) disable iff (!arst_n)
        $rose(vin.vsync) |=> vout.vs)
        else $error("vs pulse missing");

    a_vs_only: assert property (@(posedge clk_74a) disable iff (!arst_n)
        !$rose(vin.vsync) |=> !vout.vs)
        else $error("vs pulse without rising edge");

endmodule

bind arcade_top arcade_props u_props (
    .clk_74a     (clk_74a),
    .arst_n      (arst_n),
    .bridge_wr   (bridge_wr),
    .bridge_addr (bridge_addr),
    .core_reset  (core_reset),
    .cfg         (cfg),
    .cont1_key   (cont1_key),
    .p1_ctrl     (p1_ctrl),
    .coin_active (u_game_control_stage.coin_active),
    .game_ctrl   (game_ctrl),
    .vin         (vin),
    .vout        (vout)
);

// ==== tests/tb_arcade_top.sv ====
// testbench for the arcade wrapper top level
// bridge read-back, manual reset, input routing, coin and video checks

`timescale 1ns/10ps

module tb_arcade_top
    import arcade_pkg::*;
();

    localparam int WATCHDOG_CYCLES = 3000;

    logic        clk_74a;
    logic        arst_n;
    logic        bridge_wr;
    logic [31:0] bridge_addr;
    logic [31:0] bridge_wr_data;
    logic [31:0] bridge_rd_data;
    key_t        cont1_key;
    key_t        cont2_key;
    key_t        snac_p1_btn;
    key_t        snac_p2_btn;
    joy_t        snac_p1_joy;
    joy_t        snac_p2_joy;
    video_in_t   vin;
    video_out_t  vout;
    game_ctrl_t  game_ctrl;
    dip_t        dips;
    logic        core_reset;

    logic [31:0]  lfsr;
    adapter_cfg_t cur_cfg;

    arcade_top #(.RESET_CYCLES(16), .COIN_CYCLES(8)) DUT (
        .clk_74a        (clk_74a),
        .arst_n         (arst_n),
        .bridge_wr      (bridge_wr),
        .bridge_addr    (bridge_addr),
        .bridge_wr_data (bridge_wr_data),
        .bridge_rd_data (bridge_rd_data),
        .cont1_key      (cont1_key),
        .cont2_key      (cont2_key),
        .snac_p1_btn    (snac_p1_btn),
        .snac_p2_btn    (snac_p2_btn),
        .snac_p1_joy    (snac_p1_joy),
        .snac_p2_joy    (snac_p2_joy),
        .vin            (vin),
        .vout           (vout),
        .game_ctrl      (game_ctrl),
        .dips           (dips),
        .core_reset     (core_reset)
    );

    initial begin
        clk_74a = 1'b0;
        forever #2 clk_74a = ~clk_74a;
    end

    // watchdog sized well above the summed test lengths
    initial begin
        #(WATCHDOG_CYCLES * 4);
        $display("watchdog expired before the tests finished");
        $display("Done: errors found");
        $fatal(1);
    end

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return v;
    endfunction

    task automatic require(input logic ok, input string msg);
        assert (ok) else begin
            $display("CHECK FAILED at %0t ns: %s", $time, msg);
            $display("Done: errors found");
            $fatal(1);
        end
    endtask

    // drive point sits just after the rising edge
    task automatic tick();
        @(posedge clk_74a);
        #1;
    endtask

    task automatic bridge_write(input logic [31:0] addr, input logic [31:0] data);
        bridge_wr      = 1'b1;
        bridge_addr    = addr;
        bridge_wr_data = data;
        tick();
        bridge_wr = 1'b0;
    endtask

    task automatic read_expect(input logic [31:0] addr, input logic [31:0] exp);
        bridge_addr = addr;
        tick();
        require(bridge_rd_data == exp, $sformatf("read 0x%08h gave 0x%08h, want 0x%08h",
                                                 addr, bridge_rd_data, exp));
    endtask

    task automatic write_cfg(input adapter_cfg_t c);
        bridge_write(ADDR_ADAPTER_CFG, {23'd0, c});
        cur_cfg = c;
    endtask

    // threshold rule on the left stick, {up, down, left, right}
    function automatic logic [3:0] stick_dirs(input joy_t j);
        return {j.lstick_y < 8'h40, j.lstick_y > 8'hC0,
                j.lstick_x < 8'h40, j.lstick_x > 8'hC0};
    endfunction

    function automatic logic [23:0] expand_rgb(input logic [11:0] c);
        return {c[11:8], c[11:8], c[7:4], c[7:4], c[3:0], c[3:0]};
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // test sequences
    ////////////////////////////////////////////////////////////////////////////
    task automatic test_bridge();
        logic [1:0] lives;
        logic [2:0] diff;
        logic [2:0] bonus;
        logic       demo;
        logic [8:0] c;
        lives = 2'(rand_bits(2));
        diff  = 3'(rand_bits(3));
        bonus = 3'(rand_bits(3));
        demo  = 1'(rand_bits(1));
        bridge_write(ADDR_LIVES, {30'd0, lives});
        bridge_write(ADDR_DIFFICULTY, {29'd0, diff});
        bridge_write(ADDR_BONUS, {29'd0, bonus});
        bridge_write(ADDR_DEMO, {31'd0, demo});
        require(dips == {demo, 1'b0, lives, 6'd0, diff, bonus}, "dip word layout");
        bridge_write(ADDR_ADAPTER_EN, 32'd1);
        read_expect(ADDR_ADAPTER_EN, 32'd1);
        for (int i = 0; i < 4; i++) begin
            c = 9'(rand_bits(9));
            write_cfg(adapter_cfg_t'(c));
            read_expect(ADDR_ADAPTER_CFG, {23'd0, c});
            read_expect(ADDR_ADAPTER_EN, {31'd0, c[8]});
        end
        // unmapped and write-only addresses
        read_expect(32'h1234_5678, 32'd0);
        read_expect(ADDR_LIVES, 32'd0);
        read_expect(ADDR_RESET, 32'd0);
    endtask

    task automatic test_reset();
        int n;
        bridge_write(ADDR_RESET, 32'd0);
        n = 0;
        while (!core_reset && n < 4) begin
            tick();
            n++;
        end
        require(core_reset, "core_reset never rose after the reset write");
        // second request inside the window
        repeat (4) tick();
        bridge_write(ADDR_RESET, 32'd0);
        n = 5;
        while (core_reset && n < 40) begin
            tick();
            n++;
        end
        require(n == 16, $sformatf("core_reset high for %0d cycles", n));
        repeat (5) tick();
        require(!core_reset, "absorbed reset write started a new window");
    endtask

    task automatic test_handheld();
        write_cfg('0);
        for (int i = 0; i < 40; i++) begin
            cont1_key = key_t'(rand_bits(16));
            cont2_key = key_t'(rand_bits(16));
            tick();
        end
        // select release, then a second release inside the pulse
        cont1_key = '0;
        cont1_key.select = 1'b1;
        repeat (12) tick();
        cont1_key.select = 1'b0;
        repeat (3) tick();
        cont1_key.select = 1'b1;
        tick();
        cont1_key.select = 1'b0;
        repeat (14) tick();
    endtask

    task automatic test_adapter();
        key_t       exp_key;
        logic [3:0] dirs;
        for (int m = 0; m < 4; m++) begin
            write_cfg('{enable: 1'b1, cont_type: 5'h12 + 5'(m[0]),
                        assignment: 2'(m), blank_screen: 1'b0});
            for (int i = 0; i < 8; i++) begin
                cont1_key   = key_t'(rand_bits(16) & 32'hBFFF);
                snac_p1_btn = key_t'(rand_bits(16) & 32'hBFFF);
                snac_p2_btn = key_t'(rand_bits(16) & 32'hBFFF);
                snac_p1_joy = joy_t'(rand_bits(32));
                snac_p2_joy = joy_t'(rand_bits(32));
                repeat (6) tick();
                case (m)
                    1:       exp_key = cont1_key;
                    3:       exp_key = snac_p2_btn;
                    default: exp_key = snac_p1_btn;
                endcase
                dirs = (m == 1) ? {exp_key.up, exp_key.down, exp_key.left, exp_key.right}
                                : stick_dirs((m == 3) ? snac_p2_joy : snac_p1_joy);
                require({game_ctrl.up, game_ctrl.down, game_ctrl.left, game_ctrl.right}
                        == dirs, $sformatf("d-pad in assignment %0d", m));
                require(game_ctrl.fire == exp_key.a, $sformatf("fire in assignment %0d", m));
                require(game_ctrl.start == exp_key.start,
                        $sformatf("start in assignment %0d", m));
            end
        end
    endtask

    task automatic test_video();
        logic exp_de;
        for (int k = 0; k < 3; k++) begin
            write_cfg('{enable: k != 2, cont_type: 5'd0, assignment: 2'd0,
                        blank_screen: k != 0});
            for (int i = 0; i < 40; i++) begin
                vin = video_in_t'(rand_bits(16));
                tick();
                exp_de = !(vin.hblank || vin.vblank);
                require(vout.de == exp_de, "data enable");
                require(vout.rgb == ((!exp_de || (cur_cfg.blank_screen && cur_cfg.enable))
                                     ? 24'd0 : expand_rgb(vin.rgb12)), "rgb expansion");
            end
        end
    endtask

    initial begin
        lfsr           = 32'h6341;
        cur_cfg        = '0;
        arst_n         = 1'b0;
        bridge_wr      = 1'b0;
        bridge_addr    = '0;
        bridge_wr_data = '0;
        cont1_key      = '0;
        cont2_key      = '0;
        snac_p1_btn    = '0;
        snac_p2_btn    = '0;
        snac_p1_joy    = '0;
        snac_p2_joy    = '0;
        vin            = '0;
        repeat (2) tick();
        require(!core_reset && game_ctrl == '0 && !vout.de, "outputs idle in reset");
        arst_n = 1'b1;
        tick();
        test_bridge();
        test_reset();
        test_handheld();
        test_adapter();
        test_video();
        repeat (4) tick();
        $display("Done: no errors");
        $finish;
    end

endmodule

// ==== verilog.f ====
verilog/arcade_pkg.sv
verilog/sync_stage.sv
verilog/bridge_regs.sv
verilog/reset_stretch.sv
verilog/input_router.sv
verilog/game_control_stage.sv
verilog/video_formatter.sv
verilog/arcade_top.sv
tests/arcade_props.sv
tests/tb_arcade_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the arcade wrapper testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module tb_arcade_top \
    -f verilog.f \
    -o sim_tb_arcade_top
status=$?
if [ $status -ne 0 ]; then
    echo "build failed"
    exit $status
fi

./obj_dir/sim_tb_arcade_top
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed"
    exit $status
fi

exit 0
